// File: bench/tb_board_inputs.sv
// testbench for the player input path: seeded random stimulus checked against a cycle model
`timescale 1ns/1ps
`include "board_params.svh"

module tb_board_inputs;

    localparam int PLAYERS = `BOARD_PLAYERS;
    localparam int COIN_BIT = `BOARD_START_BIT + 1;
    localparam logic OUT_INV = (`BOARD_OUT_ACTIVE_LOW != 0);
    localparam logic [`BOARD_JOY_W-1:0] JOY_INV = {`BOARD_JOY_W{OUT_INV}};
    localparam logic [PLAYERS-1:0] BIT_INV = {PLAYERS{OUT_INV}};
    localparam int RANDOM_CYCLES = 2000;

    logic clk_sys;
    logic rst;
    logic [`BOARD_WORD_W-1:0] board_joystick1, board_joystick2;
    logic [`BOARD_WORD_W-1:0] board_joystick3, board_joystick4;
    logic en4way;
    logic [`BOARD_JOY_W-1:0] key_joy1, key_joy2, key_joy3;
    logic [PLAYERS-1:0] key_coin, key_start;
    logic rot_control, dip_flip;
    logic key_pause, key_reset, key_service, osd_pause, downloading;
    logic [`BOARD_GFX_W-1:0] key_gfx;
    logic [`BOARD_JOY_W-1:0] game_joystick1, game_joystick2;
    logic [`BOARD_JOY_W-1:0] game_joystick3, game_joystick4;
    logic [PLAYERS-1:0] game_coin, game_start;
    logic game_service, game_pause, soft_rst;
    logic [`BOARD_GFX_W-1:0] gfx_en;

    integer seed;

    // reference model state
    logic [`BOARD_WORD_W-1:0] hist1 [PLAYERS];
    logic [`BOARD_WORD_W-1:0] hist2 [PLAYERS];
    logic [`BOARD_DIR_W-1:0] mem4 [PLAYERS];
    logic [`BOARD_JOY_W-1:0] exp_joy [PLAYERS];
    logic [PLAYERS-1:0] exp_coin, exp_start;
    logic exp_service, exp_pause, exp_soft_rst;
    logic [`BOARD_GFX_W-1:0] exp_gfx;
    logic prev_key_pause, prev_joy_pause, prev_osd, prev_key_reset;
    logic [`BOARD_GFX_W-1:0] prev_gfx;

    board_inputs_top uut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    function automatic int count_ones(input logic [`BOARD_DIR_W-1:0] dir);
        int n;
        n = 0;
        for (int b = 0; b < `BOARD_DIR_W; b++) begin
            n += dir[b];
        end
        return n;
    endfunction

    // rotated cabinet, bit 3 up, 2 down, 1 left, 0 right
    function automatic logic [`BOARD_JOY_W-1:0] remap_dirs(
        input logic [`BOARD_JOY_W-1:0] joy,
        input logic                    rot,
        input logic                    flip
    );
        logic [`BOARD_JOY_W-1:0] res;
        res = joy;
        if (rot) begin
            res[3] = flip ? joy[0] : joy[1];
            res[2] = flip ? joy[1] : joy[0];
            res[1] = flip ? joy[3] : joy[2];
            res[0] = flip ? joy[2] : joy[3];
        end
        return res;
    endfunction

    always @(posedge clk_sys) begin : reference_model
        logic [`BOARD_WORD_W-1:0] word_in [PLAYERS];
        logic [`BOARD_JOY_W-1:0] key_in [PLAYERS];
        logic [`BOARD_JOY_W-1:0] joy_m [PLAYERS];
        logic [PLAYERS-1:0] coin_m, start_m;
        logic pause_m;
        logic [`BOARD_DIR_W-1:0] dir, dir_f;
        word_in[0] = board_joystick1;
        word_in[1] = board_joystick2;
        word_in[2] = board_joystick3;
        word_in[3] = board_joystick4;
        key_in[0] = key_joy1;
        key_in[1] = key_joy2;
        key_in[2] = key_joy3;
        key_in[3] = '0;
        // mapping of the words leaving the second capture stage
        coin_m = key_coin;
        start_m = key_start;
        for (int p = 0; p < PLAYERS; p++) begin
            joy_m[p] = remap_dirs(hist2[p][`BOARD_JOY_W-1:0] | key_in[p], rot_control, dip_flip);
            coin_m[p] = coin_m[p] | hist2[p][COIN_BIT];
            start_m[p] = start_m[p] | hist2[p][`BOARD_START_BIT];
        end
        pause_m = hist2[0][`BOARD_PAUSE_BIT] | hist2[1][`BOARD_PAUSE_BIT];
        if (rst) begin
            for (int p = 0; p < PLAYERS; p++) exp_joy[p] = JOY_INV;
            exp_coin = BIT_INV;
            exp_start = BIT_INV;
            exp_service = OUT_INV;
            exp_pause = 1'b0;
            exp_soft_rst = 1'b0;
            exp_gfx = '1;
            {prev_key_pause, prev_joy_pause, prev_osd, prev_key_reset} = 4'b0000;
            prev_gfx = '0;
        end else begin
            for (int p = 0; p < PLAYERS; p++) exp_joy[p] = joy_m[p] ^ JOY_INV;
            exp_coin = coin_m ^ BIT_INV;
            exp_start = start_m ^ BIT_INV;
            exp_service = key_service ^ OUT_INV;
            exp_soft_rst = key_reset && !prev_key_reset;
            exp_gfx = exp_gfx ^ (key_gfx & ~prev_gfx);
            if (downloading) begin
                exp_pause = 1'b0;
            end else if (osd_pause != prev_osd) begin
                exp_pause = osd_pause;
            end else if ((key_pause && !prev_key_pause) || (pause_m && !prev_joy_pause)) begin
                exp_pause = !exp_pause;
            end
            prev_key_pause = key_pause;
            prev_joy_pause = pause_m;
            prev_osd = osd_pause;
            prev_key_reset = key_reset;
            prev_gfx = key_gfx;
        end
        // 4-way reduction between the two capture stages
        for (int p = 0; p < PLAYERS; p++) begin
            dir = hist1[p][`BOARD_DIR_W-1:0];
            if (!en4way || count_ones(dir) == 1) dir_f = dir;
            else if (count_ones(dir) == 0) dir_f = '0;
            else dir_f = mem4[p];
            if (rst) mem4[p] = '0;
            else if (en4way) mem4[p] = dir_f;
            hist2[p] = {hist1[p][`BOARD_WORD_W-1:`BOARD_DIR_W], dir_f};
            hist1[p] = word_in[p];
        end
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t signal %s actual %h expected %h",
                     $time, name, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic next_cycle;
        @(negedge clk_sys);
        check_value("game_joystick1", game_joystick1, exp_joy[0]);
        check_value("game_joystick2", game_joystick2, exp_joy[1]);
        check_value("game_joystick3", game_joystick3, exp_joy[2]);
        check_value("game_joystick4", game_joystick4, exp_joy[3]);
        check_value("game_coin", game_coin, exp_coin);
        check_value("game_start", game_start, exp_start);
        check_value("game_service", game_service, exp_service);
        check_value("game_pause", game_pause, exp_pause);
        check_value("soft_rst", soft_rst, exp_soft_rst);
        check_value("gfx_en", gfx_en, exp_gfx);
    endtask

    task automatic drive_random;
        logic [31:0] r;
        board_joystick1 = $random(seed);
        board_joystick2 = $random(seed);
        board_joystick3 = $random(seed);
        board_joystick4 = $random(seed);
        // sparse keys so the board side still shows through
        key_joy1 = $random(seed) & $random(seed) & $random(seed);
        key_joy2 = $random(seed) & $random(seed) & $random(seed);
        key_joy3 = $random(seed) & $random(seed) & $random(seed);
        key_coin = $random(seed) & $random(seed);
        key_start = $random(seed) & $random(seed);
        key_gfx = key_gfx ^ ($random(seed) & $random(seed));
        r = $random(seed);
        if (r[3:0] == 0) en4way = !en4way;
        rot_control = r[4];
        dip_flip = r[5];
        if (r[7:6] == 0) key_pause = !key_pause;
        if (r[10:8] == 0) key_reset = !key_reset;
        key_service = r[11];
        if (r[16:12] == 0) osd_pause = !osd_pause;
        if (downloading) begin
            if (r[19:17] == 0) downloading = 1'b0;
        end else if (r[25:20] == 0) begin
            downloading = 1'b1;
        end
    endtask

    task automatic wait_soft_rst(input int limit);
        int n;
        n = 0;
        while (soft_rst !== 1'b1) begin
            if (n == limit) begin
                $display("soft reset pulse did not appear within %0d cycles", limit);
                $display("RESULT: FAIL");
                $fatal(1, "timeout");
            end
            next_cycle();
            n++;
        end
    endtask

    initial begin
        logic [`BOARD_GFX_W-1:0] gfx_start;
        logic pause_target;
        seed = 95660;
        rst = 1'b1;
        {board_joystick1, board_joystick2, board_joystick3, board_joystick4} = '0;
        {key_joy1, key_joy2, key_joy3, key_coin, key_start} = '0;
        {en4way, rot_control, dip_flip, key_pause, key_reset} = '0;
        {key_service, osd_pause, downloading} = '0;
        key_gfx = '0;
        for (int p = 0; p < PLAYERS; p++) begin
            hist1[p] = '0;
            hist2[p] = '0;
            mem4[p] = '0;
        end
        repeat (2) @(posedge clk_sys);
        @(negedge clk_sys);
        // state right after reset
        check_value("gfx_en", gfx_en, {`BOARD_GFX_W{1'b1}});
        check_value("game_pause", game_pause, 1'b0);
        check_value("soft_rst", soft_rst, 1'b0);
        check_value("game_service", game_service, OUT_INV);
        check_value("game_joystick1", game_joystick1, JOY_INV);
        check_value("game_joystick2", game_joystick2, JOY_INV);
        check_value("game_joystick3", game_joystick3, JOY_INV);
        check_value("game_joystick4", game_joystick4, JOY_INV);
        check_value("game_coin", game_coin, BIT_INV);
        check_value("game_start", game_start, BIT_INV);
        rst = 1'b0;
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            drive_random();
            next_cycle();
        end
        // quiet inputs, then directed edges
        {board_joystick1, board_joystick2, board_joystick3, board_joystick4} = '0;
        {key_pause, key_reset, key_service, downloading} = '0;
        key_gfx = '0;
        repeat (4) next_cycle();
        key_reset = 1'b1;
        wait_soft_rst(4);
        next_cycle();
        check_value("soft_rst", soft_rst, 1'b0);
        key_service = 1'b1;
        next_cycle();
        check_value("game_service", game_service, !OUT_INV);
        gfx_start = gfx_en;
        key_gfx = 4'b0101;
        next_cycle();
        check_value("gfx_en", gfx_en, gfx_start ^ 4'b0101);
        repeat (3) next_cycle();
        check_value("gfx_en", gfx_en, gfx_start ^ 4'b0101);
        // osd change loads its level, then a key press toggles it
        pause_target = !osd_pause;
        osd_pause = pause_target;
        next_cycle();
        check_value("game_pause", game_pause, pause_target);
        key_pause = 1'b1;
        next_cycle();
        check_value("game_pause", game_pause, !pause_target);
        downloading = 1'b1;
        next_cycle();
        check_value("game_pause", game_pause, 1'b0);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: board_inputs.f
+incdir+hw
hw/board_pkg.sv
hw/board_if.sv
hw/joy_capture.sv
hw/joy_mapper.sv
hw/board_ctrl.sv
hw/board_inputs_top.sv
bench/tb_board_inputs.sv

// File: hw/board_ctrl.sv
// board control: game-facing output registers, pause state, soft reset pulse, layer toggles
`timescale 1ns/1ps
`include "board_params.svh"

module board_ctrl (
    input  logic                      clk_sys,
    input  logic                      rst,
    map_bus_if.sink                   map,
    input  logic                      key_pause,
    input  logic                      key_reset,
    input  logic                      key_service,
    input  logic                      osd_pause,
    input  logic                      downloading,
    input  logic [`BOARD_GFX_W-1:0]   key_gfx,
    output logic [`BOARD_JOY_W-1:0]   game_joystick1,
    output logic [`BOARD_JOY_W-1:0]   game_joystick2,
    output logic [`BOARD_JOY_W-1:0]   game_joystick3,
    output logic [`BOARD_JOY_W-1:0]   game_joystick4,
    output logic [`BOARD_PLAYERS-1:0] game_coin,
    output logic [`BOARD_PLAYERS-1:0] game_start,
    output logic                      game_service,
    output logic                      game_pause,
    output logic                      soft_rst,
    output logic [`BOARD_GFX_W-1:0]   gfx_en
);

    // polarity masks, all ones for an active low game
    localparam logic OUT_INV = (`BOARD_OUT_ACTIVE_LOW != 0);
    localparam logic [`BOARD_JOY_W-1:0] JOY_INV = {`BOARD_JOY_W{OUT_INV}};
    localparam logic [`BOARD_PLAYERS-1:0] BIT_INV = {`BOARD_PLAYERS{OUT_INV}};

    logic last_key_pause;
    logic last_joy_pause;
    logic last_osd_pause;
    logic last_key_reset;
    logic [`BOARD_GFX_W-1:0] last_gfx;

    logic pause_rise;
    logic reset_rise;
    logic [`BOARD_GFX_W-1:0] gfx_rise;

    assign pause_rise = (key_pause & ~last_key_pause) | (map.joy_pause & ~last_joy_pause);
    assign reset_rise = key_reset & ~last_key_reset;
    assign gfx_rise = key_gfx & ~last_gfx;

    // inputs seen by the game
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            game_joystick1 <= JOY_INV;
            game_joystick2 <= JOY_INV;
            game_joystick3 <= JOY_INV;
            game_joystick4 <= JOY_INV;
            game_coin <= BIT_INV;
            game_start <= BIT_INV;
            game_service <= OUT_INV;
        end else begin
            game_joystick1 <= map.joy[0] ^ JOY_INV;
            game_joystick2 <= map.joy[1] ^ JOY_INV;
            game_joystick3 <= map.joy[2] ^ JOY_INV;
            game_joystick4 <= map.joy[3] ^ JOY_INV;
            game_coin <= map.coin ^ BIT_INV;
            game_start <= map.start ^ BIT_INV;
            game_service <= key_service ^ OUT_INV;
        end
    end

    // previous samples for edge detection
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            last_key_pause <= 1'b0;
            last_joy_pause <= 1'b0;
            last_osd_pause <= 1'b0;
            last_key_reset <= 1'b0;
            last_gfx <= '0;
        end else begin
            last_key_pause <= key_pause;
            last_joy_pause <= map.joy_pause;
            last_osd_pause <= osd_pause;
            last_key_reset <= key_reset;
            last_gfx <= key_gfx;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            soft_rst <= 1'b0;
            game_pause <= 1'b0;
            gfx_en <= '1;
        end else begin
            soft_rst <= reset_rise;
            gfx_en <= gfx_en ^ gfx_rise;
            // download wins, then the OSD, then the buttons
            if (downloading) begin
                game_pause <= 1'b0;
            end else if (osd_pause != last_osd_pause) begin
                game_pause <= osd_pause;
            end else if (pause_rise) begin
                game_pause <= ~game_pause;
            end
        end
    end

    a_soft_rst_pulse: assert property (
        @(posedge clk_sys) disable iff (rst)
        soft_rst |=> !soft_rst
    );

    a_download_unpause: assert property (
        @(posedge clk_sys) disable iff (rst)
        downloading |=> !game_pause
    );

endmodule

// File: hw/board_if.sv
// buses between the capture, mapping and control stages of the input path
`timescale 1ns/1ps
`include "board_params.svh"

// captured board words, direction already filtered
interface cap_bus_if
    import board_pkg::*;
();

    // one word per player, player 1 at index 0
    board_word_t word [`BOARD_PLAYERS];

    modport source (
        output word
    );

    modport sink (
        input word
    );

endinterface

// mapped player inputs before the output registers
interface map_bus_if ();

    // game joysticks after key merge and rotation
    logic [`BOARD_JOY_W-1:0] joy [`BOARD_PLAYERS];
    // one bit per player
    logic [`BOARD_PLAYERS-1:0] coin;
    logic [`BOARD_PLAYERS-1:0] start;
    // pause button of player 1 or 2
    logic joy_pause;

    modport source (
        output joy,
        output coin,
        output start,
        output joy_pause
    );

    modport sink (
        input joy,
        input coin,
        input start,
        input joy_pause
    );

endinterface

// File: hw/board_inputs_top.sv
// player input path top: capture, mapping and control stages joined by their buses
`timescale 1ns/1ps
`include "board_params.svh"

module board_inputs_top (
    input  logic                      clk_sys,
    input  logic                      rst,
    input  logic [`BOARD_WORD_W-1:0]  board_joystick1,
    input  logic [`BOARD_WORD_W-1:0]  board_joystick2,
    input  logic [`BOARD_WORD_W-1:0]  board_joystick3,
    input  logic [`BOARD_WORD_W-1:0]  board_joystick4,
    input  logic                      en4way,
    input  logic [`BOARD_JOY_W-1:0]   key_joy1,
    input  logic [`BOARD_JOY_W-1:0]   key_joy2,
    input  logic [`BOARD_JOY_W-1:0]   key_joy3,
    input  logic [`BOARD_PLAYERS-1:0] key_coin,
    input  logic [`BOARD_PLAYERS-1:0] key_start,
    input  logic                      rot_control,
    input  logic                      dip_flip,
    input  logic                      key_pause,
    input  logic                      key_reset,
    input  logic                      key_service,
    input  logic                      osd_pause,
    input  logic                      downloading,
    input  logic [`BOARD_GFX_W-1:0]   key_gfx,
    output logic [`BOARD_JOY_W-1:0]   game_joystick1,
    output logic [`BOARD_JOY_W-1:0]   game_joystick2,
    output logic [`BOARD_JOY_W-1:0]   game_joystick3,
    output logic [`BOARD_JOY_W-1:0]   game_joystick4,
    output logic [`BOARD_PLAYERS-1:0] game_coin,
    output logic [`BOARD_PLAYERS-1:0] game_start,
    output logic                      game_service,
    output logic                      game_pause,
    output logic                      soft_rst,
    output logic [`BOARD_GFX_W-1:0]   gfx_en
);

    cap_bus_if u_cap_bus ();
    map_bus_if u_map_bus ();

    // two register stages
    joy_capture u_capture (
        .clk_sys         (clk_sys),
        .rst             (rst),
        .board_joystick1 (board_joystick1),
        .board_joystick2 (board_joystick2),
        .board_joystick3 (board_joystick3),
        .board_joystick4 (board_joystick4),
        .en4way          (en4way),
        .cap             (u_cap_bus.source)
    );

    // purely combinational
    joy_mapper u_mapper (
        .cap         (u_cap_bus.sink),
        .key_joy1    (key_joy1),
        .key_joy2    (key_joy2),
        .key_joy3    (key_joy3),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .rot_control (rot_control),
        .dip_flip    (dip_flip),
        .map         (u_map_bus.source)
    );

    board_ctrl u_ctrl (
        .clk_sys        (clk_sys),
        .rst            (rst),
        .map            (u_map_bus.sink),
        .key_pause      (key_pause),
        .key_reset      (key_reset),
        .key_service    (key_service),
        .osd_pause      (osd_pause),
        .downloading    (downloading),
        .key_gfx        (key_gfx),
        .game_joystick1 (game_joystick1),
        .game_joystick2 (game_joystick2),
        .game_joystick3 (game_joystick3),
        .game_joystick4 (game_joystick4),
        .game_coin      (game_coin),
        .game_start     (game_start),
        .game_service   (game_service),
        .game_pause     (game_pause),
        .soft_rst       (soft_rst),
        .gfx_en         (gfx_en)
    );

endmodule

// File: hw/board_params.svh
// board input path constants: word widths, field positions, player counts, output polarity
`ifndef BOARD_PARAMS_SVH
`define BOARD_PARAMS_SVH

// joystick ports on the board
`define BOARD_PLAYERS 4

// players that also take keyboard keys
`define BOARD_KEY_PLAYERS 3

// board word as delivered by the host, and the part the game sees
`define BOARD_WORD_W 16
`define BOARD_JOY_W 10

// direction nibble sits in the low bits: right, left, down, up
`define BOARD_DIR_W 4

// two buttons sit above the directions, so start and pause are fixed
`define BOARD_START_BIT 6
`define BOARD_PAUSE_BIT 8

// graphics layer enables driven to the game
`define BOARD_GFX_W 4

// 1 when the game inputs are active low
`define BOARD_OUT_ACTIVE_LOW 1

`endif

// File: hw/board_pkg.sv
// board joystick word types: raw vector and the decoded field view of the same word
`include "board_params.svh"

package board_pkg;

    // field view of one board joystick word, msb first
    typedef struct packed {
        // unused upper bits
        logic [`BOARD_WORD_W-`BOARD_PAUSE_BIT-2:0] spare;
        logic pause;
        logic coin;
        logic start;
        // fire buttons, two of them
        logic [`BOARD_START_BIT-`BOARD_DIR_W-1:0] button;
        // up, down, left, right from bit 3 down
        logic [`BOARD_DIR_W-1:0] dir;
    } board_fields_t;

    // the same 16 bits read two ways
    // raw feeds the game joystick, fields feed coin/start/pause and the 4-way filter
    typedef union packed {
        logic [`BOARD_WORD_W-1:0] raw;
        board_fields_t f;
    } board_word_t;

endpackage

// File: hw/joy_capture.sv
// joystick capture: registers the board words and reduces directions to 4-way on demand
`timescale 1ns/1ps
`include "board_params.svh"

module joy_capture
    import board_pkg::*;
(
    input  logic                     clk_sys,
    input  logic                     rst,
    input  logic [`BOARD_WORD_W-1:0] board_joystick1,
    input  logic [`BOARD_WORD_W-1:0] board_joystick2,
    input  logic [`BOARD_WORD_W-1:0] board_joystick3,
    input  logic [`BOARD_WORD_W-1:0] board_joystick4,
    input  logic                     en4way,
    cap_bus_if.source                cap
);

    logic [`BOARD_WORD_W-1:0] joy_in   [`BOARD_PLAYERS];
    logic [`BOARD_WORD_W-1:0] joy_sync [`BOARD_PLAYERS];

    assign joy_in = '{board_joystick1, board_joystick2, board_joystick3, board_joystick4};

    // first stage, raw words straight from the board
    always_ff @(posedge clk_sys) begin
        joy_sync <= joy_in;
    end

    for (genvar i = 0; i < `BOARD_PLAYERS; i++) begin : g_player
        board_word_t word_sync;
        board_word_t word_filt;
        board_word_t word_out;
        logic [`BOARD_DIR_W-1:0] dir_in;
        logic [`BOARD_DIR_W-1:0] dir_out;
        // last direction handed out in 4-way mode
        logic [`BOARD_DIR_W-1:0] dir_mem;
        logic dir_at_most_one;

        assign word_sync = joy_sync[i];
        assign dir_in = word_sync.f.dir;

        // true for no direction or a single one
        assign dir_at_most_one = (dir_in & (dir_in - 1'b1)) == '0;

        // diagonals keep whatever went out before
        always_comb begin
            if (!en4way || dir_at_most_one) begin
                dir_out = dir_in;
            end else begin
                dir_out = dir_mem;
            end
        end

        always_ff @(posedge clk_sys) begin
            if (rst) begin
                dir_mem <= '0;
            end else if (en4way) begin
                dir_mem <= dir_out;
            end
        end

        // rest of the word rides along unchanged
        always_comb begin
            word_filt = word_sync;
            word_filt.f.dir = dir_out;
        end

        // second stage
        always_ff @(posedge clk_sys) begin
            word_out <= word_filt;
        end

        assign cap.word[i] = word_out;

        // 4-way mode never lets a diagonal reach the mapper
        a_dir_4way: assert property (
            @(posedge clk_sys) disable iff (rst)
            en4way |=> $onehot0(word_out.f.dir)
        );
    end

endmodule

// File: hw/joy_mapper.sv
// joystick mapper: merges keyboard keys, rotates directions, gathers coin, start and pause
`timescale 1ns/1ps
`include "board_params.svh"

module joy_mapper
    import board_pkg::*;
(
    cap_bus_if.sink                   cap,
    input  logic [`BOARD_JOY_W-1:0]   key_joy1,
    input  logic [`BOARD_JOY_W-1:0]   key_joy2,
    input  logic [`BOARD_JOY_W-1:0]   key_joy3,
    input  logic [`BOARD_PLAYERS-1:0] key_coin,
    input  logic [`BOARD_PLAYERS-1:0] key_start,
    input  logic                      rot_control,
    input  logic                      dip_flip,
    map_bus_if.source                 map
);

    logic [`BOARD_JOY_W-1:0]   key_joy [`BOARD_KEY_PLAYERS];
    logic [`BOARD_PLAYERS-1:0] coin_vec;
    logic [`BOARD_PLAYERS-1:0] start_vec;

    // direction remap for a rotated cabinet
    // bit order is up, down, left, right from bit 3
    function automatic logic [`BOARD_JOY_W-1:0] rotate_joy(
        input logic [`BOARD_JOY_W-1:0] joy,
        input logic                    rot,
        input logic                    flip
    );
        logic [`BOARD_JOY_W-1:0] res;
        res = joy;
        if (rot) begin
            if (flip) begin
                res[`BOARD_DIR_W-1:0] = {joy[0], joy[1], joy[3], joy[2]};
            end else begin
                res[`BOARD_DIR_W-1:0] = {joy[1], joy[0], joy[2], joy[3]};
            end
        end
        return res;
    endfunction

    assign key_joy = '{key_joy1, key_joy2, key_joy3};

    for (genvar i = 0; i < `BOARD_PLAYERS; i++) begin : g_player
        board_word_t word;
        logic [`BOARD_JOY_W-1:0] merged;

        assign word = cap.word[i];

        if (i < `BOARD_KEY_PLAYERS) begin : g_key
            assign merged = word.raw[`BOARD_JOY_W-1:0] | key_joy[i];
        end else begin : g_no_key
            // last player has no keyboard keys
            assign merged = word.raw[`BOARD_JOY_W-1:0];
        end

        assign map.joy[i] = rotate_joy(merged, rot_control, dip_flip);
    end

    // coin and start from every port plus the keyboard
    always_comb begin
        coin_vec = key_coin;
        start_vec = key_start;
        for (int i = 0; i < `BOARD_PLAYERS; i++) begin
            coin_vec[i] = coin_vec[i] | cap.word[i].f.coin;
            start_vec[i] = start_vec[i] | cap.word[i].f.start;
        end
    end

    assign map.coin = coin_vec;
    assign map.start = start_vec;

    // only the first two players can pause
    assign map.joy_pause = cap.word[0].f.pause | cap.word[1].f.pause;

endmodule
